// ==== all.f ====
+incdir+rtl
+incdir+test
rtl/rv_isa_pkg.sv
rtl/rv_exec_pkg.sv
rtl/exec_stage_if.sv
rtl/instr_decode.sv
rtl/alu.sv
rtl/branch_resolve.sv
rtl/rv_exec_top.sv
test/tb_rv_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the execute path testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f all.f --top-module tb_rv_exec -Mdir obj_dir; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_rv_exec)
status=$?
echo "$sim_out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

// ==== test/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    reg_idx_t rd;
    xlen_t    result;
    logic     zero;
    logic     carry;
    logic     overflow;
    logic     taken;
    xlen_t    next_pc;
    logic     illegal;
} expect_t;

// operation classes of the model
typedef enum int {
    k_add, k_sub, k_and, k_or, k_xor, k_sll,
    k_srl, k_sra, k_slt, k_sltu, k_pass
} ref_kind_e;

// funct3 of the arithmetic groups, alt is instr bit 30
function automatic int arith_kind(logic [2:0] f3, logic alt);
    case (f3)
        3'd0:    return alt ? k_sub : k_add;
        3'd1:    return k_sll;
        3'd2:    return k_slt;
        3'd3:    return k_sltu;
        3'd4:    return k_xor;
        3'd5:    return alt ? k_sra : k_srl;
        3'd6:    return k_or;
        default: return k_and;
    endcase
endfunction

function automatic void alu_ref(input int kind, input xlen_t x, input xlen_t y,
                                output xlen_t r, output logic c, output logic v);
    int sh;
    sh = int'(y[4:0]);
    r  = '0;
    c  = 1'b0;
    v  = 1'b0;
    case (kind)
        k_add:
        begin
            r = x + y;
            c = (r < x);                     // wrapped past the top
            v = (longint'($signed(x)) + longint'($signed(y))) != longint'($signed(r));
        end
        k_sub:
        begin
            r = x - y;
            c = (x >= y);                    // no borrow
            v = (longint'($signed(x)) - longint'($signed(y))) != longint'($signed(r));
        end
        k_and:  r = x & y;
        k_or:   r = x | y;
        k_xor:  r = x ^ y;
        k_sll:
        begin
            r = x << sh;
            c = (sh == 0) ? 1'b0 : x[32-sh];
        end
        k_srl, k_sra:
        begin
            r = (kind == k_sra) ? xlen_t'($signed(x) >>> sh) : (x >> sh);
            c = (sh == 0) ? 1'b0 : x[sh-1];
        end
        k_slt, k_sltu:
        begin
            c = (kind == k_slt) ? ($signed(x) < $signed(y)) : (x < y);
            r = {31'b0, c};
        end
        default: r = y;
    endcase
endfunction

function automatic expect_t ref_exec(instr_t ins, xlen_t pc_v, xlen_t a, xlen_t b);
    expect_t    e;
    logic [2:0] f3;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      r;
    logic       c;
    logic       v;
    f3    = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    e         = '0;
    e.rd      = ins[11:7];
    e.next_pc = pc_v + 32'd4;
    r         = '0;
    c         = 1'b0;
    v         = 1'b0;
    case (ins[6:0])
        op_lui:   alu_ref(k_pass, 32'd0, imm_u, r, c, v);
        op_auipc: alu_ref(k_add, pc_v, imm_u, r, c, v);
        op_jal, op_jalr:
        begin
            alu_ref(k_add, pc_v, 32'd4, r, c, v);   // link value
            e.taken   = 1'b1;
            e.next_pc = (ins[6:0] == op_jal) ? pc_v + imm_j : ((a + imm_i) & 32'hffff_fffe);
        end
        op_branch:
        begin
            case (f3)
                3'd0:    e.taken = (a == b);
                3'd1:    e.taken = (a != b);
                3'd4:    e.taken = ($signed(a) < $signed(b));
                3'd5:    e.taken = ($signed(a) >= $signed(b));
                3'd6:    e.taken = (a < b);
                default: e.taken = (a >= b);
            endcase
            if (f3[2])
                alu_ref(f3[1] ? k_sltu : k_slt, a, b, r, c, v);
            else
                alu_ref(k_sub, a, b, r, c, v);
            e.rd = '0;                               // branches write no register
            if (e.taken)
                e.next_pc = pc_v + imm_b;
        end
        op_imm:   alu_ref(arith_kind(f3, (f3 == 3'd5) && ins[30]), a, imm_i, r, c, v);
        op_reg:   alu_ref(arith_kind(f3, ins[30]), a, b, r, c, v);
        default:  e.illegal = 1'b1;
    endcase
    e.result   = r;
    e.carry    = c;
    e.overflow = v;
    e.zero     = !e.illegal && (r == 32'd0);
    return e;
endfunction

`endif

// ==== test/tb_rv_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec
    import rv_isa_pkg::*;
();

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    localparam int n_arith   = 40;
    localparam int n_shift   = 30;
    localparam int n_branch  = 36;
    localparam int n_jump    = 16;
    localparam int n_illegal = 8;
    localparam int n_stream  = 100;
    localparam int n_total   = n_arith + n_shift + n_branch + n_jump + n_illegal + n_stream;

    `include "tb_ref_model.svh"

    logic     clk_in;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    instr_t   instr;
    xlen_t    pc;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    logic     out_valid;
    logic     out_ready;
    reg_idx_t out_rd;
    xlen_t    out_result;
    logic     out_zero;
    logic     out_carry;
    logic     out_overflow;
    logic     out_taken;
    xlen_t    out_next_pc;
    logic     out_illegal;

    integer  seed = 32'h80da_0406;
    expect_t exp_q[$];
    int      pass_count = 0;
    int      fail_count = 0;
    logic    random_ready = 1'b0;

    rv_exec_top u_rv_exec_top (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .instr        (instr),
        .pc           (pc),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_rd       (out_rd),
        .out_result   (out_result),
        .out_zero     (out_zero),
        .out_carry    (out_carry),
        .out_overflow (out_overflow),
        .out_taken    (out_taken),
        .out_next_pc  (out_next_pc),
        .out_illegal  (out_illegal)
    );

    initial clk_in = 1'b0;
    always #20 clk_in = ~clk_in;

    // downstream back-pressure
    always @(posedge clk_in)
        out_ready <= random_ready ? (($random(seed) & 1) != 0) : 1'b1;

    function automatic xlen_t rand_word();
        case ($random(seed) & 7)
            0:       return 32'h7fff_ffff;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h0000_0000;
            default: return $random(seed);
        endcase
    endfunction

    function automatic xlen_t rand_pc();
        return {30'($random(seed)), 2'b00};
    endfunction

    task automatic check_field(input string name, input logic [31:0] expv, input logic [31:0] actv);
        if (expv !== actv)
        begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expv, actv);
            fail_count++;
        end
        else
            pass_count++;
    endtask

    // called on a rising edge, returns on the edge that accepts
    task automatic send_instr(input instr_t ins, input xlen_t pc_v, input xlen_t a, input xlen_t b);
        logic ok;
        in_valid <= 1'b1;
        instr    <= ins;
        pc       <= pc_v;
        rs1_val  <= a;
        rs2_val  <= b;
        exp_q.push_back(ref_exec(ins, pc_v, a, b));
        ok = 1'b0;
        while (!ok)
        begin
            @(negedge clk_in);
            ok = in_ready;
            @(posedge clk_in);
        end
    endtask

    task automatic gen_arith();
        logic [2:0] f3;
        logic       alt;
        f3  = 3'($random(seed));
        alt = 1'($random(seed));
        if (f3 == 3'd1 || f3 == 3'd5)
            f3 = 3'd0;                       // shifts get their own test
        if (($random(seed) & 1) != 0)
            send_instr({12'($random(seed)), 5'd1, f3, 5'($random(seed)), op_imm},
                       rand_pc(), rand_word(), rand_word());
        else
            send_instr({1'b0, alt && (f3 == 3'd0), 5'd0, 5'd2, 5'd1, f3, 5'($random(seed)), op_reg},
                       rand_pc(), rand_word(), rand_word());
    endtask

    task automatic gen_shift(input logic [4:0] amt);
        logic [2:0] f3;
        logic       alt;
        f3  = (($random(seed) & 1) != 0) ? 3'd5 : 3'd1;
        alt = (f3 == 3'd5) && (($random(seed) & 1) != 0);
        if (($random(seed) & 1) != 0)
            send_instr({1'b0, alt, 5'd0, amt, 5'd1, f3, 5'($random(seed)), op_imm},
                       rand_pc(), rand_word(), rand_word());
        else
            send_instr({1'b0, alt, 5'd0, 5'd2, 5'd1, f3, 5'($random(seed)), op_reg},
                       rand_pc(), rand_word(), {27'($random(seed)), amt});
    endtask

    task automatic gen_branch(input logic [2:0] f3, input int relation);
        logic [12:0] imm;
        xlen_t       a;
        xlen_t       b;
        imm = {12'($random(seed)), 1'b0};
        a   = rand_word();
        case (relation)
            0:       b = a;
            1:       b = a + 32'd1 + 32'($random(seed) & 255);
            2:       b = a - 32'd1 - 32'($random(seed) & 255);
            3:
            begin
                a = a | 32'h8000_0000;       // negative versus positive
                b = {1'b0, 31'($random(seed))};
            end
            4:
            begin
                a = a & 32'h7fff_ffff;
                b = {1'b1, 31'($random(seed))};
            end
            default:
            begin
                a = '0;
                b = '0;
            end
        endcase
        send_instr({imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], op_branch},
                   rand_pc(), a, b);
    endtask

    task automatic gen_jump(input int kind);
        logic [20:0] imm;
        imm = {20'($random(seed)), 1'b0};
        case (kind)
            0:       send_instr({20'($random(seed)), 5'd3, op_lui}, rand_pc(), rand_word(), 0);
            1:       send_instr({20'($random(seed)), 5'd3, op_auipc}, rand_pc(), rand_word(), 0);
            2:       send_instr({imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, op_jal},
                                rand_pc(), rand_word(), rand_word());
            default: send_instr({12'($random(seed)), 5'd1, 3'd0, 5'd1, op_jalr},
                                rand_pc(), $random(seed), rand_word());   // odd bases too
        endcase
    endtask

    task automatic drain_and_report(input string name, input int count, input int fails_before);
        in_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk_in);
        $display("%-8s %0d instructions, %0d errors", name, count, fail_count - fails_before);
    endtask

    // one transfer per edge where valid and ready were high before it
    always @(negedge clk_in)
    begin
        expect_t e;
        if (rst_n && out_valid && out_ready)
        begin
            if (exp_q.size() == 0)
            begin
                $display("error at %0t: output without a pending instruction", $time);
                fail_count++;
            end
            else
            begin
                e = exp_q.pop_front();
                check_field("out_rd", 32'(e.rd), 32'(out_rd));
                check_field("out_result", e.result, out_result);
                check_field("out_zero", 32'(e.zero), 32'(out_zero));
                check_field("out_carry", 32'(e.carry), 32'(out_carry));
                check_field("out_overflow", 32'(e.overflow), 32'(out_overflow));
                check_field("out_taken", 32'(e.taken), 32'(out_taken));
                check_field("out_next_pc", e.next_pc, out_next_pc);
                check_field("out_illegal", 32'(e.illegal), 32'(out_illegal));
            end
        end
    end

    initial
    begin
        repeat (n_total * 8 + 200) @(posedge clk_in);
        $display("error: run hung, results stopped arriving");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        int              i;
        int              start;
        logic [6:0]      bad_opc [8];
        logic [2:0]      br_f3 [6];
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1_val   = '0;
        rs2_val   = '0;
        out_ready = 1'b1;
        bad_opc   = '{7'b0000011, 7'b0100011, 7'b1110011, 7'b0001111,
                      7'b0000000, 7'b1111111, 7'b1010111, 7'b0101111};
        br_f3     = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        repeat (8) @(posedge clk_in);
        rst_n <= 1'b1;
        @(negedge clk_in);
        start = fail_count;
        if (out_valid !== 1'b0)
        begin
            $display("error: out_valid is not low after reset");
            fail_count++;
        end
        if (in_ready !== 1'b1)
        begin
            $display("error: in_ready is not high after reset");
            fail_count++;
        end
        $display("%-8s %0d errors", "reset", fail_count - start);
        @(posedge clk_in);

        start = fail_count;
        for (i = 0; i < n_arith; i++)
            gen_arith();
        drain_and_report("arith", n_arith, start);

        start = fail_count;
        for (i = 0; i < n_shift; i++)
            gen_shift((i < 4) ? 5'd0 : 5'($random(seed)));
        drain_and_report("shift", n_shift, start);

        start = fail_count;
        for (i = 0; i < n_branch; i++)
            gen_branch(br_f3[i % 6], i / 6);
        drain_and_report("branch", n_branch, start);

        start = fail_count;
        for (i = 0; i < n_jump; i++)
            gen_jump(i % 4);
        drain_and_report("jump", n_jump, start);

        start = fail_count;
        for (i = 0; i < n_illegal; i++)
            send_instr({25'($random(seed)), bad_opc[i]}, rand_pc(), rand_word(), rand_word());
        drain_and_report("illegal", n_illegal, start);

        start = fail_count;
        random_ready = 1'b1;
        for (i = 0; i < n_stream; i++)
        begin
            case ($random(seed) & 3)
                0:       gen_arith();
                1:       gen_shift(5'($random(seed)));
                2:       gen_branch(br_f3[($random(seed) & 32'h7fff) % 6], ($random(seed) & 7) % 6);
                default: gen_jump($random(seed) & 3);
            endcase
        end
        drain_and_report("stream", n_stream, start);
        random_ready = 1'b0;

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/rv_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top
    import rv_isa_pkg::*;
(
    input  logic     clk_in,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  instr_t   instr,
    input  xlen_t    pc,
    input  xlen_t    rs1_val,
    input  xlen_t    rs2_val,
    output logic     out_valid,
    input  logic     out_ready,
    output reg_idx_t out_rd,
    output xlen_t    out_result,
    output logic     out_zero,
    output logic     out_carry,
    output logic     out_overflow,
    output logic     out_taken,
    output xlen_t    out_next_pc,
    output logic     out_illegal
);

    exec_stage_if s12_if ();   // decode to alu
    exec_stage_if s23_if ();   // alu to branch resolve

    instr_decode u_instr_decode (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .instr    (instr),
        .pc       (pc),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .dn       (s12_if)
    );

    alu u_alu (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .up     (s12_if),
        .dn     (s23_if)
    );

    branch_resolve u_branch_resolve (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .up           (s23_if),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_rd       (out_rd),
        .out_result   (out_result),
        .out_zero     (out_zero),
        .out_carry    (out_carry),
        .out_overflow (out_overflow),
        .out_taken    (out_taken),
        .out_next_pc  (out_next_pc),
        .out_illegal  (out_illegal)
    );

endmodule

`default_nettype wire

// ==== rtl/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module branch_resolve
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic       clk_in,
    input  logic       rst_n,
    exec_stage_if.sink up,
    output logic       out_valid,
    input  logic       out_ready,
    output reg_idx_t   out_rd,
    output xlen_t      out_result,
    output logic       out_zero,
    output logic       out_carry,
    output logic       out_overflow,
    output logic       out_taken,
    output xlen_t      out_next_pc,
    output logic       out_illegal
);

    logic  taken_d;
    xlen_t target;
    xlen_t next_pc_d;
    logic  load;

    always_comb
    begin
        taken_d = 1'b0;
        case (up.xfer)
            xfer_branch:
            begin
                case (up.funct3)
                    f3_beq:           taken_d = up.zero;
                    f3_bne:           taken_d = !up.zero;
                    f3_blt, f3_bltu:  taken_d = up.carry;     // slt bit
                    f3_bge, f3_bgeu:  taken_d = !up.carry;
                    default:          taken_d = 1'b0;
                endcase
            end
            xfer_jal, xfer_jalr: taken_d = 1'b1;
            default:             taken_d = 1'b0;
        endcase
    end

    // jalr target has bit 0 cleared
    assign target    = (up.xfer == xfer_jalr) ? ((up.rs1_val + up.imm) & ~xlen_t'(1))
                                              : (up.pc + up.imm);
    assign next_pc_d = taken_d ? target : (up.pc + xlen_t'(4));

    assign up.ready = !out_valid || out_ready;
    assign load     = up.valid && up.ready;

    always_ff @(posedge clk_in or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid   <= 1'b0;
            out_next_pc <= `RESET_PC;
        end
        else
        begin
            if (up.ready)
                out_valid <= up.valid;
            if (load)
                out_next_pc <= next_pc_d;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (load)
        begin
            out_rd       <= (up.xfer == xfer_branch) ? reg_idx_t'(0) : up.rd;  // no writeback
            out_result   <= up.result;
            out_zero     <= up.zero;
            out_carry    <= up.carry;
            out_overflow <= up.overflow;
            out_taken    <= taken_d;
            out_illegal  <= up.illegal;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module alu
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_n,
    exec_stage_if.sink   up,
    exec_stage_if.source dn
);

    logic [`SHAMT_W-1:0] shamt;
    logic [`XLEN:0]      ext;        // one spare bit for carry or shifted-out bit
    xlen_t               res;
    logic                carry_d;
    logic                ovf_d;
    logic                zero_d;
    logic                lt;
    logic                load;

    assign shamt = up.op2[`SHAMT_W-1:0];

    always_comb
    begin
        ext     = '0;
        res     = '0;
        carry_d = 1'b0;
        ovf_d   = 1'b0;
        lt      = 1'b0;
        case (up.alu_op)
            alu_add:
            begin
                ext     = {1'b0, up.op1} + {1'b0, up.op2};
                res     = ext[`XLEN-1:0];
                carry_d = ext[`XLEN];
                ovf_d   = (up.op1[`XLEN-1] == up.op2[`XLEN-1]) &&
                          (res[`XLEN-1] != up.op1[`XLEN-1]);
            end
            alu_sub:
            begin
                ext     = {1'b0, up.op1} + {1'b0, ~up.op2} + 1'b1;
                res     = ext[`XLEN-1:0];
                carry_d = ext[`XLEN];      // high when no borrow
                ovf_d   = (up.op1[`XLEN-1] != up.op2[`XLEN-1]) &&
                          (res[`XLEN-1] != up.op1[`XLEN-1]);
            end
            alu_and:  res = up.op1 & up.op2;
            alu_or:   res = up.op1 | up.op2;
            alu_xor:  res = up.op1 ^ up.op2;
            alu_sll:
            begin
                ext     = {1'b0, up.op1} << shamt;
                res     = ext[`XLEN-1:0];
                carry_d = ext[`XLEN];      // zero for shamt 0
            end
            alu_srl:
            begin
                ext     = {up.op1, 1'b0} >> shamt;
                res     = ext[`XLEN:1];
                carry_d = ext[0];
            end
            alu_sra:
            begin
                ext     = $signed({up.op1, 1'b0}) >>> shamt;
                res     = ext[`XLEN:1];
                carry_d = ext[0];
            end
            alu_slt, alu_sltu:
            begin
                lt      = (up.alu_op == alu_slt) ? ($signed(up.op1) < $signed(up.op2))
                                                 : (up.op1 < up.op2);
                res     = xlen_t'(lt);
                carry_d = lt;
            end
            default:  res = up.op2;        // pass
        endcase

        // illegal entries leave with everything cleared
        if (up.illegal)
        begin
            res     = '0;
            carry_d = 1'b0;
            ovf_d   = 1'b0;
        end
    end

    assign zero_d = !up.illegal && (res == '0);

    assign up.ready = !dn.valid || dn.ready;
    assign load     = up.valid && up.ready;

    always_ff @(posedge clk_in or negedge rst_n)
    begin
        if (!rst_n)
            dn.valid <= 1'b0;
        else if (up.ready)
            dn.valid <= up.valid;
    end

    always_ff @(posedge clk_in)
    begin
        if (load)
        begin
            dn.alu_op   <= up.alu_op;
            dn.op1      <= up.op1;
            dn.op2      <= up.op2;
            dn.pc       <= up.pc;
            dn.imm      <= up.imm;
            dn.rs1_val  <= up.rs1_val;
            dn.rd       <= up.rd;
            dn.xfer     <= up.xfer;
            dn.funct3   <= up.funct3;
            dn.illegal  <= up.illegal;
            dn.result   <= res;
            dn.zero     <= zero_d;
            dn.carry    <= carry_d;
            dn.overflow <= ovf_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_config.svh"

module instr_decode
    import rv_isa_pkg::*, rv_exec_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  instr_t       instr,
    input  xlen_t        pc,
    input  xlen_t        rs1_val,
    input  xlen_t        rs2_val,
    exec_stage_if.source dn
);

    opcode_e    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;
    alu_op_e    op_d;
    xlen_t      op1_d;
    xlen_t      op2_d;
    xlen_t      imm_d;
    xfer_e      xfer_d;
    logic       illegal_d;
    logic       load;

    // op and op_imm share funct3, funct7[5] picks sub and sra
    function automatic alu_op_e arith_op(funct3_t f3, logic sub_en, logic sra_en);
        case (f3)
            f3_add:  return sub_en ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return sra_en ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_b = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        op_d      = alu_add;
        op1_d     = rs1_val;
        op2_d     = rs2_val;
        imm_d     = '0;
        xfer_d    = xfer_none;
        illegal_d = 1'b0;
        case (opcode)
            opc_lui:
            begin
                op_d  = alu_pass;
                op1_d = '0;
                op2_d = imm_u;
                imm_d = imm_u;
            end
            opc_auipc:
            begin
                op1_d = pc;
                op2_d = imm_u;
                imm_d = imm_u;
            end
            opc_jal, opc_jalr:
            begin
                op1_d  = pc;               // link value pc + 4
                op2_d  = xlen_t'(4);
                imm_d  = (opcode == opc_jal) ? imm_j : imm_i;
                xfer_d = (opcode == opc_jal) ? xfer_jal : xfer_jalr;
            end
            opc_branch:
            begin
                imm_d  = imm_b;
                xfer_d = xfer_branch;
                case (funct3)
                    f3_blt, f3_bge:   op_d = alu_slt;
                    f3_bltu, f3_bgeu: op_d = alu_sltu;
                    default:          op_d = alu_sub;   // beq, bne use zero
                endcase
            end
            opc_op_imm:
            begin
                op_d  = arith_op(funct3, 1'b0, funct7[5]);
                op2_d = imm_i;
                imm_d = imm_i;
            end
            opc_op:
            begin
                op_d = arith_op(funct3, funct7[5], funct7[5]);
            end
            default:
            begin
                op_d      = alu_pass;
                op1_d     = '0;
                op2_d     = '0;
                illegal_d = 1'b1;          // loads, stores, system, unknown
            end
        endcase
    end

    assign in_ready = !dn.valid || dn.ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk_in or negedge rst_n)
    begin
        if (!rst_n)
            dn.valid <= 1'b0;
        else if (in_ready)
            dn.valid <= in_valid;
    end

    always_ff @(posedge clk_in)
    begin
        if (load)
        begin
            dn.alu_op  <= op_d;
            dn.op1     <= op1_d;
            dn.op2     <= op2_d;
            dn.pc      <= pc;
            dn.imm     <= imm_d;
            dn.rs1_val <= rs1_val;
            dn.rd      <= rd;
            dn.xfer    <= xfer_d;
            dn.funct3  <= funct3;
            dn.illegal <= illegal_d;
        end
    end

    // result and flags are produced downstream
    assign dn.result   = '0;
    assign dn.zero     = 1'b0;
    assign dn.carry    = 1'b0;
    assign dn.overflow = 1'b0;

endmodule

`default_nettype wire

// ==== rtl/exec_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exec_stage_if
    import rv_isa_pkg::*, rv_exec_pkg::*;
();

    logic     valid;
    logic     ready;
    alu_op_e  alu_op;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    pc;
    xlen_t    imm;
    xlen_t    rs1_val;     // jalr base
    reg_idx_t rd;
    xfer_e    xfer;
    funct3_t  funct3;      // branch condition
    logic     illegal;
    xlen_t    result;      // filled by the alu stage
    logic     zero;
    logic     carry;
    logic     overflow;

    modport source (
        output valid, alu_op, op1, op2, pc, imm, rs1_val, rd, xfer, funct3, illegal,
        output result, zero, carry, overflow,
        input  ready
    );

    modport sink (
        input  valid, alu_op, op1, op2, pc, imm, rs1_val, rd, xfer, funct3, illegal,
        input  result, zero, carry, overflow,
        output ready
    );

endinterface

`default_nettype wire

// ==== rtl/rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    // operation performed by the alu stage
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0001,
        alu_and  = 4'b0010,
        alu_or   = 4'b0011,
        alu_xor  = 4'b0100,
        alu_sll  = 4'b0101,
        alu_srl  = 4'b0110,
        alu_sra  = 4'b0111,
        alu_slt  = 4'b1000,
        alu_sltu = 4'b1001,
        alu_pass = 4'b1010   // result is op2
    } alu_op_e;

    // control transfer resolved in stage 3
    typedef enum logic [1:0] {
        xfer_none   = 2'b00,
        xfer_branch = 2'b01,
        xfer_jal    = 2'b10,
        xfer_jalr   = 2'b11
    } xfer_e;

endpackage

`default_nettype wire

// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

`include "rv_exec_config.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] xlen_t;      // data word, pc, immediate
    typedef logic [4:0]       reg_idx_t;   // register index
    typedef logic [31:0]      instr_t;     // instruction word
    typedef logic [2:0]       funct3_t;

    // major opcodes kept by the execute path
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    // branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // arithmetic group, shared by op and op_imm
    localparam funct3_t f3_add  = 3'b000;   // add, sub, addi
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;   // srl or sra by funct7
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

endpackage

`default_nettype wire

// ==== rtl/rv_exec_config.svh ====
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// data path width of the execute path
`define XLEN 32

// low bits of operand 2 taken as the shift amount
`define SHAMT_W 5

// next pc seen on the output before the first instruction retires
`define RESET_PC 32'h0000_0000

`endif
